// File: udp_tx_pkg.sv
package udp_tx_pkg;

    // ==============================
    // Datapath
    // ==============================
    localparam int DATA_W    = 32;          // Stream data width
    localparam int KEEP_W    = DATA_W / 8;  // One enable per byte lane
    localparam int HDR_IDX_W = 4;           // Wide enough for the header beat count
    localparam int HDR_BEATS = 10;          // Full header beats, bytes 0..39

    // Header lengths, added to the payload length
    localparam logic [15:0] IP_HDR_BYTES  = 16'd20;
    localparam logic [15:0] UDP_HDR_BYTES = 16'd8;

    // ==============================
    // Fixed header fields
    // ==============================
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;    // IPv4, five words of header
    localparam logic [15:0] IP_FLAGS_DF    = 16'h4000; // Don't fragment, offset 0
    localparam logic [7:0]  IP_TTL         = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [15:0] IP_ID_INIT     = 16'd1;    // First frame carries ID 1

    // Beat number inside the header
    typedef logic [HDR_IDX_W-1:0] hdr_idx_t;

    // ==============================
    // Sequencer FSM
    // ==============================
    typedef enum logic [1:0] {
        ST_IDLE,     // Waiting for a header
        ST_HEADER,   // Sending beats 0..9
        ST_PAYLOAD   // Mixed beat, payload and flush
    } seq_state_t;

endpackage

// File: udp_hdr_capture.sv
`timescale 1ns/1ns

module udp_hdr_capture (
    input  logic        iClk,
    input  logic        arst_n,
    input  logic        hdr_take,      // Header handshake this cycle
    input  logic [15:0] payload_len,
    input  logic [31:0] src_ip,
    input  logic [31:0] dst_ip,
    input  logic [15:0] src_port,
    input  logic [15:0] dst_port,
    input  logic        frame_done,    // Last beat of a frame left
    output logic [31:0] src_ip_q,
    output logic [31:0] dst_ip_q,
    output logic [15:0] src_port_q,
    output logic [15:0] dst_port_q,
    output logic [15:0] total_len,
    output logic [15:0] udp_len,
    output logic [15:0] ip_id,
    output logic [15:0] ip_csum
);
    import udp_tx_pkg::*;

    logic [19:0] csum_sum;    // Ten half-words, room for the carries
    logic [16:0] csum_fold1;
    logic [15:0] csum_fold2;

    // Latch fields and lengths in the accept cycle
    always_ff @(posedge iClk) begin
        if (hdr_take) begin
            src_ip_q   <= src_ip;
            dst_ip_q   <= dst_ip;
            src_port_q <= src_port;
            dst_port_q <= dst_port;
            total_len  <= payload_len + IP_HDR_BYTES + UDP_HDR_BYTES; // IP + UDP + data
            udp_len    <= payload_len + UDP_HDR_BYTES;
        end
    end

    // Identification, one step per finished frame
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            ip_id <= IP_ID_INIT;
        end else if (frame_done) begin
            ip_id <= ip_id + 16'd1;
        end
    end

    // IPv4 header sum, checksum field counted as zero
    always_comb begin
        csum_sum = 20'({IP_VER_IHL, 8'h00}) + 20'(total_len) + 20'(ip_id)
                 + 20'(IP_FLAGS_DF) + 20'({IP_TTL, IP_PROTO_UDP})
                 + 20'(src_ip_q[31:16]) + 20'(src_ip_q[15:0])
                 + 20'(dst_ip_q[31:16]) + 20'(dst_ip_q[15:0]);
        csum_fold1 = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);
        csum_fold2 = csum_fold1[15:0] + 16'(csum_fold1[16]);  // Second fold cannot carry
    end

    // Follows the latched fields one edge behind, so a late ID step is picked up
    always_ff @(posedge iClk) begin
        ip_csum <= ~csum_fold2;
    end

endmodule

// File: eth_hdr_builder.sv
`timescale 1ns/1ns

module eth_hdr_builder #(
    parameter logic [47:0] SRC_MAC = 48'h123456789ABC,
    parameter logic [47:0] DST_MAC = 48'h000A35010203
) (
    input  udp_tx_pkg::hdr_idx_t hdr_idx,     // Which header beat
    input  logic [31:0]          src_ip_q,
    input  logic [31:0]          dst_ip_q,
    input  logic [15:0]          src_port_q,
    input  logic [15:0]          dst_port_q,
    input  logic [15:0]          total_len,
    input  logic [15:0]          udp_len,
    input  logic [15:0]          ip_id,
    input  logic [15:0]          ip_csum,
    output logic [31:0]          hdr_word
);
    import udp_tx_pkg::*;

    // Lane 0 goes first on the wire, so a big-endian half-word is swapped
    function automatic logic [15:0] be16(input logic [15:0] v);
        be16 = {v[7:0], v[15:8]};
    endfunction

    // ==============================
    // Header bytes 0..39, four per beat
    // ==============================
    always_comb begin
        case (hdr_idx)
            4'd0: hdr_word = {be16(DST_MAC[31:16]), be16(DST_MAC[47:32])};
            4'd1: hdr_word = {be16(SRC_MAC[47:32]), be16(DST_MAC[15:0])};
            4'd2: hdr_word = {be16(SRC_MAC[15:0]), be16(SRC_MAC[31:16])};
            4'd3: hdr_word = {8'h00, IP_VER_IHL,           // DSCP/ECN zero
                              be16(ETHERTYPE_IPV4)};
            4'd4: hdr_word = {be16(ip_id), be16(total_len)};
            4'd5: hdr_word = {IP_PROTO_UDP, IP_TTL, be16(IP_FLAGS_DF)};
            4'd6: hdr_word = {be16(src_ip_q[31:16]), be16(ip_csum)};
            4'd7: hdr_word = {be16(dst_ip_q[31:16]), be16(src_ip_q[15:0])};
            4'd8: hdr_word = {be16(src_port_q), be16(dst_ip_q[15:0])};
            4'd9: hdr_word = {be16(udp_len), be16(dst_port_q)};
            // Bytes 40..41 come out of the aligner as the zero UDP checksum
            default: hdr_word = '0;
        endcase
    end

endmodule

// File: udp_payload_aligner.sv
`timescale 1ns/1ns

module udp_payload_aligner (
    input  logic                          iClk,
    input  logic                          arst_n,
    input  logic                          start,          // Header accepted
    input  logic                          take,           // Payload beat accepted
    input  logic [udp_tx_pkg::DATA_W-1:0] s_tdata,
    input  logic [udp_tx_pkg::KEEP_W-1:0] s_tkeep,
    input  logic                          s_tlast,
    input  logic                          flush_done,     // Flush beat loaded
    output logic [udp_tx_pkg::DATA_W-1:0] aligned_data,
    output logic [udp_tx_pkg::KEEP_W-1:0] aligned_keep,
    output logic                          aligned_end,
    output logic                          flush_pending,
    output logic [udp_tx_pkg::DATA_W-1:0] flush_data,
    output logic [udp_tx_pkg::KEEP_W-1:0] flush_keep
);
    import udp_tx_pkg::*;

    localparam int HALF_W = DATA_W / 2;

    logic [HALF_W-1:0] hold;      // Upper two bytes of the previous beat
    logic [1:0]        rem_keep;  // Bytes left for the flush beat

    // ==============================
    // Holding register
    // ==============================
    always_ff @(posedge iClk) begin
        if (start) begin
            hold <= '0;                        // Becomes the UDP checksum
        end else if (take) begin
            hold <= s_tdata[DATA_W-1:HALF_W];
        end
    end

    // Last beat with three or four bytes leaves a tail behind
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            flush_pending <= 1'b0;
            rem_keep      <= '0;
        end else if (start || flush_done) begin
            flush_pending <= 1'b0;
        end else if (take && s_tlast && s_tkeep[2]) begin
            flush_pending <= 1'b1;
            rem_keep      <= s_tkeep[3:2];         // One or two bytes
        end
    end

    // Held bytes in the low lanes, new bytes above
    assign aligned_data = {s_tdata[HALF_W-1:0], hold};
    assign aligned_end  = s_tlast && !s_tkeep[2];  // Keep is contiguous from lane 0

    // Held lanes always carry bytes, input keep trims the upper two
    assign aligned_keep = {s_tkeep[1:0], 2'b11};

    assign flush_data = {{HALF_W{1'b0}}, hold};
    assign flush_keep = {2'b00, rem_keep};

endmodule

// File: udp_frame_sequencer.sv
`timescale 1ns/1ns

module udp_frame_sequencer (
    input  logic                          iClk,
    input  logic                          arst_n,
    input  logic                          hdr_valid,
    input  logic [udp_tx_pkg::DATA_W-1:0] hdr_word,
    input  logic [udp_tx_pkg::DATA_W-1:0] aligned_data,
    input  logic [udp_tx_pkg::KEEP_W-1:0] aligned_keep,
    input  logic                          aligned_end,
    input  logic                          flush_pending,
    input  logic [udp_tx_pkg::DATA_W-1:0] flush_data,
    input  logic [udp_tx_pkg::KEEP_W-1:0] flush_keep,
    input  logic                          s_tvalid,
    input  logic                          m_tready,
    output logic                          hdr_ready,
    output logic                          hdr_take,
    output udp_tx_pkg::hdr_idx_t          hdr_idx,
    output logic                          start,
    output logic                          take,
    output logic                          flush_done,
    output logic                          frame_done,
    output logic                          s_tready,
    output logic [udp_tx_pkg::DATA_W-1:0] m_tdata,
    output logic [udp_tx_pkg::KEEP_W-1:0] m_tkeep,
    output logic                          m_tvalid,
    output logic                          m_tlast
);
    import udp_tx_pkg::*;

    seq_state_t          state;
    logic                hdr_arm;     // Settle cycle after accept
    logic                slot_free;   // Output register can take a beat
    logic                load_en;
    logic [DATA_W-1:0]   load_data;
    logic [KEEP_W-1:0]   load_keep;
    logic                load_last;

    assign slot_free  = !m_tvalid || m_tready;
    assign hdr_ready  = (state == ST_IDLE);
    assign hdr_take   = hdr_valid && hdr_ready;
    assign start      = hdr_take;                            // Aligner clears its hold
    assign s_tready   = (state == ST_PAYLOAD) && !flush_pending && slot_free;
    assign take       = s_tvalid && s_tready;
    assign frame_done = m_tvalid && m_tready && m_tlast;

    // ==============================
    // Next output beat
    // ==============================
    always_comb begin
        load_en    = 1'b0;
        load_data  = hdr_word;
        load_keep  = '1;
        load_last  = 1'b0;
        flush_done = 1'b0;
        case (state)
            ST_HEADER: load_en = !hdr_arm && slot_free;
            ST_PAYLOAD: begin
                if (flush_pending) begin
                    load_en    = slot_free;
                    flush_done = slot_free;
                    load_data  = flush_data;
                    load_keep  = flush_keep;
                    load_last  = 1'b1;                       // Tail always ends the frame
                end else begin
                    load_en   = take;
                    load_data = aligned_data;
                    load_keep = aligned_keep;
                    load_last = aligned_end;
                end
            end
            default: load_en = 1'b0;
        endcase
    end

    // FSM and header beat counter
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            hdr_arm <= 1'b0;
            hdr_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: if (hdr_take) begin
                    state   <= ST_HEADER;
                    hdr_arm <= 1'b1;
                    hdr_idx <= '0;
                end
                ST_HEADER: begin
                    hdr_arm <= 1'b0;
                    if (load_en) begin
                        if (hdr_idx == hdr_idx_t'(HDR_BEATS - 1)) begin
                            state <= ST_PAYLOAD;             // Mixed beat comes next
                        end else begin
                            hdr_idx <= hdr_idx + 1'b1;
                        end
                    end
                end
                ST_PAYLOAD: if (load_en && load_last) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ==============================
    // Output register
    // ==============================
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            m_tvalid <= 1'b0;
            m_tlast  <= 1'b0;
        end else if (load_en) begin
            m_tvalid <= 1'b1;
            m_tlast  <= load_last;
        end else if (m_tready) begin
            m_tvalid <= 1'b0;                                // Beat left, slot empty
            m_tlast  <= 1'b0;
        end
    end

    always_ff @(posedge iClk) begin
        if (load_en) begin
            m_tdata <= load_data;                            // Held while stalled
            m_tkeep <= load_keep;
        end
    end

endmodule

// File: udp_tx_top.sv
`timescale 1ns/1ns

module udp_tx_top #(
    parameter logic [47:0] SRC_MAC = 48'h123456789ABC,
    parameter logic [47:0] DST_MAC = 48'h000A35010203
) (
    input  logic                          iClk,
    input  logic                          arst_n,
    // Header handshake
    input  logic                          hdr_valid,
    output logic                          hdr_ready,
    input  logic [15:0]                   payload_len,
    input  logic [31:0]                   src_ip,
    input  logic [31:0]                   dst_ip,
    input  logic [15:0]                   src_port,
    input  logic [15:0]                   dst_port,
    // Payload stream in
    input  logic [udp_tx_pkg::DATA_W-1:0] s_tdata,
    input  logic [udp_tx_pkg::KEEP_W-1:0] s_tkeep,
    input  logic                          s_tvalid,
    output logic                          s_tready,
    input  logic                          s_tlast,
    // Frame stream out
    output logic [udp_tx_pkg::DATA_W-1:0] m_tdata,
    output logic [udp_tx_pkg::KEEP_W-1:0] m_tkeep,
    output logic                          m_tvalid,
    input  logic                          m_tready,
    output logic                          m_tlast
);
    import udp_tx_pkg::*;

    logic              hdr_take, frame_done, start, take, flush_done;
    hdr_idx_t          hdr_idx;
    logic [DATA_W-1:0] hdr_word, aligned_data, flush_data;
    logic [KEEP_W-1:0] aligned_keep, flush_keep;
    logic              aligned_end, flush_pending;
    logic [31:0]       src_ip_q, dst_ip_q;
    logic [15:0]       src_port_q, dst_port_q, total_len, udp_len, ip_id, ip_csum;

    udp_hdr_capture u_capture (
        .iClk, .arst_n, .hdr_take, .payload_len, .src_ip, .dst_ip, .src_port,
        .dst_port, .frame_done, .src_ip_q, .dst_ip_q, .src_port_q, .dst_port_q,
        .total_len, .udp_len, .ip_id, .ip_csum
    );

    eth_hdr_builder #(.SRC_MAC(SRC_MAC), .DST_MAC(DST_MAC)) u_builder (
        .hdr_idx, .src_ip_q, .dst_ip_q, .src_port_q, .dst_port_q,
        .total_len, .udp_len, .ip_id, .ip_csum, .hdr_word
    );

    udp_payload_aligner u_aligner (
        .iClk, .arst_n, .start, .take, .s_tdata, .s_tkeep, .s_tlast, .flush_done,
        .aligned_data, .aligned_keep, .aligned_end, .flush_pending, .flush_data, .flush_keep
    );

    udp_frame_sequencer u_sequencer (
        .iClk, .arst_n, .hdr_valid, .hdr_word, .aligned_data, .aligned_keep, .aligned_end,
        .flush_pending, .flush_data, .flush_keep, .s_tvalid, .m_tready, .hdr_ready,
        .hdr_take, .hdr_idx, .start, .take, .flush_done, .frame_done, .s_tready,
        .m_tdata, .m_tkeep, .m_tvalid, .m_tlast
    );

endmodule

// File: tb_udp_tx.sv
`timescale 1ns/1ns

module tb_udp_tx;
    import udp_tx_pkg::*;

    localparam int          NUM_FRAMES = 40;
    localparam int          MAX_PAY    = 40;                  // Longest payload in bytes
    localparam int          TIMEOUT    = NUM_FRAMES * 60 * 4; // Cycles for the whole run
    localparam logic [47:0] SRC_MAC    = 48'h123456789ABC;
    localparam logic [47:0] DST_MAC    = 48'h000A35010203;

    logic              iClk = 1'b0;
    logic              arst_n;
    logic              hdr_valid, hdr_ready;
    logic [15:0]       payload_len, src_port, dst_port;
    logic [31:0]       src_ip, dst_ip;
    logic [DATA_W-1:0] s_tdata, m_tdata;
    logic [KEEP_W-1:0] s_tkeep, m_tkeep;
    logic              s_tvalid, s_tready, s_tlast, m_tvalid, m_tlast;
    logic              m_tready = 1'b0;

    int seed         = 93060;
    int mismatch_cnt = 0;
    int error_cnt    = 0;
    int frames_seen  = 0;
    int cycles       = 0;
    bit run_started  = 1'b0;      // Sink starts throttling after reset
    bit ready_draw   = 1'b0;      // Next m_tready value

    // Stimulus of every frame, kept for the reference
    int          plen   [NUM_FRAMES];
    logic [31:0] f_sip  [NUM_FRAMES];
    logic [31:0] f_dip  [NUM_FRAMES];
    logic [15:0] f_sport[NUM_FRAMES];
    logic [15:0] f_dport[NUM_FRAMES];
    logic [7:0]  pay    [NUM_FRAMES][MAX_PAY];

    udp_tx_top u_udp_tx_top (.*);

    always #50 iClk = ~iClk;      // 100 ns period

    // ==============================
    // Reference frame
    // ==============================
    // IPv4 header byte k, checksum field left at zero
    function automatic logic [7:0] ip_hdr_byte(input int f, input int k);
        logic [15:0] tot;
        logic [15:0] id;
        tot = 16'(plen[f] + 28);
        id  = 16'(f + 1);         // First frame carries ID 1
        case (k)
            0: return 8'h45;
            2: return tot[15:8];
            3: return tot[7:0];
            4: return id[15:8];
            5: return id[7:0];
            6: return 8'h40;      // DF set, offset 0
            8: return 8'd64;      // TTL
            9: return 8'd17;      // UDP
            12, 13, 14, 15: return f_sip[f][8*(15-k) +: 8];
            16, 17, 18, 19: return f_dip[f][8*(19-k) +: 8];
            default: return 8'h00;
        endcase
    endfunction

    // Two folds cover a sum of ten half-words
    function automatic logic [15:0] fold_sum(input logic [31:0] s);
        logic [31:0] t;
        t = {16'h0, s[15:0]} + {16'h0, s[31:16]};
        t = {16'h0, t[15:0]} + {16'h0, t[31:16]};
        return t[15:0];
    endfunction

    function automatic logic [15:0] ip_checksum(input int f);
        logic [31:0] s;
        int          i;
        s = '0;
        for (i = 0; i < 20; i += 2) begin
            s = s + {16'h0, ip_hdr_byte(f, i), ip_hdr_byte(f, i + 1)};
        end
        return ~fold_sum(s);
    endfunction

    // Byte i of frame f as it must appear on the wire
    function automatic logic [7:0] expected_byte(input int f, input int i);
        logic [15:0] csum;
        logic [15:0] ulen;
        csum = ip_checksum(f);
        ulen = 16'(plen[f] + 8);
        if (i < 6) return DST_MAC[8*(5-i) +: 8];
        else if (i < 12) return SRC_MAC[8*(11-i) +: 8];
        else if (i == 12) return 8'h08;                 // EtherType IPv4
        else if (i == 13) return 8'h00;
        else if (i == 24) return csum[15:8];
        else if (i == 25) return csum[7:0];
        else if (i < 34) return ip_hdr_byte(f, i - 14);
        else if (i < 36) return f_sport[f][8*(35-i) +: 8];
        else if (i < 38) return f_dport[f][8*(37-i) +: 8];
        else if (i < 40) return ulen[8*(39-i) +: 8];
        else if (i < 42) return 8'h00;                  // UDP checksum zero
        else return pay[f][i-42];
    endfunction

    // ==============================
    // Drivers
    // ==============================
    task automatic send_header(input int f);
        @(negedge iClk);
        hdr_valid   = 1'b1;
        payload_len = 16'(plen[f]);
        src_ip      = f_sip[f];
        dst_ip      = f_dip[f];
        src_port    = f_sport[f];
        dst_port    = f_dport[f];
        #10;                                            // Look once the low phase settled
        while (hdr_ready !== 1'b1) begin
            @(negedge iClk);
            #10;
        end
        @(negedge iClk);                                // Taken at the edge in between
        hdr_valid = 1'b0;
    endtask

    task automatic drive_payload(input int f);
        int pos_in;
        int n;
        int gap;
        int k;
        pos_in = 0;
        while (pos_in < plen[f]) begin
            n   = (plen[f] - pos_in > 4) ? 4 : plen[f] - pos_in;
            gap = int'($unsigned($random(seed)) % 3);
            @(negedge iClk);
            if (gap != 0) begin                         // Idle cycles on s_tvalid
                s_tvalid = 1'b0;
                repeat (gap) @(negedge iClk);
            end
            for (k = 0; k < KEEP_W; k++) begin
                if (k < n) s_tdata[8*k +: 8] = pay[f][pos_in + k];
                else s_tdata[8*k +: 8] = 8'($random(seed));  // Junk in unused lanes
            end
            s_tkeep  = KEEP_W'((1 << n) - 1);
            s_tlast  = (pos_in + n == plen[f]);
            s_tvalid = 1'b1;
            #10;
            while (s_tready !== 1'b1) begin
                @(negedge iClk);
                #10;
            end
            pos_in += n;
        end
        @(negedge iClk);
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // Random back-pressure, about one cycle in four
    always @(posedge iClk) begin
        if (run_started) begin
            ready_draw = ($unsigned($random(seed)) % 4) != 0;
        end
    end

    always @(negedge iClk) begin
        m_tready = ready_draw;
    end

    // ==============================
    // Comparing process
    // ==============================
    int                pos = 0;
    int                beats = 0;
    logic [7:0]        rx [42];           // Header bytes as received
    bit                prev_stall = 1'b0;
    logic [DATA_W-1:0] prev_data;
    logic [KEEP_W-1:0] prev_keep;
    logic              prev_last;

    always @(posedge iClk) begin
        int                total;
        int                j;
        logic [7:0]        got;
        logic [KEEP_W-1:0] exp_keep;
        logic [31:0]       s;
        if (prev_stall && (m_tvalid !== 1'b1 || m_tdata !== prev_data
                || m_tkeep !== prev_keep || m_tlast !== prev_last)) begin
            $display("Output beat changed while stalled at %0t", $time);
            error_cnt++;
        end
        prev_stall = m_tvalid && !m_tready;
        prev_data  = m_tdata;
        prev_keep  = m_tkeep;
        prev_last  = m_tlast;
        if (m_tvalid && m_tready && frames_seen >= NUM_FRAMES) begin
            $display("Unexpected output beat after the last frame at %0t", $time);
            error_cnt++;
        end else if (m_tvalid && m_tready) begin
            total = 42 + plen[frames_seen];
            beats++;
            for (j = 0; j < KEEP_W; j++) begin
                if (m_tkeep[j]) begin
                    got = m_tdata[8*j +: 8];
                    if (pos < 42) rx[pos] = got;
                    if (pos >= total) begin
                        $display("Frame %0d has more bytes than expected at %0t", frames_seen,
                                 $time);
                        error_cnt++;
                    end else if (got !== expected_byte(frames_seen, pos)) begin
                        $display("Mismatch at %0t: frame %0d byte %0d expected %02h got %02h",
                                 $time, frames_seen, pos, expected_byte(frames_seen, pos), got);
                        mismatch_cnt++;
                    end
                    pos++;
                end
            end
            if (!m_tlast && m_tkeep !== '1) begin
                $display("Mismatch at %0t: frame %0d keep %b on an inner beat", $time,
                         frames_seen, m_tkeep);
                mismatch_cnt++;
            end
            if (m_tlast) begin
                exp_keep = (total % 4 == 0) ? 4'hF : KEEP_W'((1 << (total % 4)) - 1);
                if (m_tkeep !== exp_keep || pos != total || beats != (total + 3) / 4) begin
                    $display("Mismatch at %0t: frame %0d last keep %b/%b bytes %0d/%0d beats %0d",
                             $time, frames_seen, exp_keep, m_tkeep, total, pos, beats);
                    mismatch_cnt++;
                end
                s = '0;
                for (j = 0; j < 10; j++) begin
                    s = s + {16'h0, rx[14 + 2*j], rx[15 + 2*j]};
                end
                if (fold_sum(s) !== 16'hFFFF) begin           // Valid header sums to all ones
                    $display("Mismatch at %0t: frame %0d IP header sum %04h", $time,
                             frames_seen, fold_sum(s));
                    mismatch_cnt++;
                end
                frames_seen++;
                pos   = 0;
                beats = 0;
            end
        end
    end

    always @(posedge iClk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, %0d of %0d frames seen", cycles, frames_seen,
                     NUM_FRAMES);
            $display("Errors: %0d mismatches, %0d other errors", mismatch_cnt, error_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int f;
        arst_n      = 1'b0;
        hdr_valid   = 1'b0;
        payload_len = '0;
        src_ip      = '0;
        dst_ip      = '0;
        src_port    = '0;
        dst_port    = '0;
        s_tdata     = '0;
        s_tkeep     = '0;
        s_tvalid    = 1'b0;
        s_tlast     = 1'b0;
        for (f = 0; f < NUM_FRAMES; f++) begin
            // Lengths 1..6 end in the mixed beat, a flush beat and a normal beat
            if (f < 6) plen[f] = f + 1;
            else plen[f] = 1 + int'($unsigned($random(seed)) % MAX_PAY);
            f_sip[f]   = $random(seed);
            f_dip[f]   = $random(seed);
            f_sport[f] = 16'($random(seed));
            f_dport[f] = 16'($random(seed));
            for (int k = 0; k < MAX_PAY; k++) begin
                pay[f][k] = 8'($random(seed));
            end
        end
        repeat (16) @(posedge iClk);
        @(negedge iClk);
        arst_n = 1'b1;
        #10;
        if (m_tvalid !== 1'b0 || s_tready !== 1'b0 || hdr_ready !== 1'b1) begin
            $display("Wrong state after reset: m_tvalid=%b s_tready=%b hdr_ready=%b",
                     m_tvalid, s_tready, hdr_ready);
            error_cnt++;
        end
        run_started = 1'b1;
        for (f = 0; f < NUM_FRAMES; f++) begin
            send_header(f);
            drive_payload(f);
        end
        while (frames_seen < NUM_FRAMES) @(posedge iClk);
        repeat (4) @(posedge iClk);                     // Catch stray beats
        $display("Errors: %0d mismatches, %0d other errors", mismatch_cnt, error_cnt);
        if (mismatch_cnt == 0 && error_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
udp_tx_pkg.sv
udp_hdr_capture.sv
eth_hdr_builder.sv
udp_payload_aligner.sv
udp_frame_sequencer.sv
udp_tx_top.sv
tb_udp_tx.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_udp_tx
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
